/* common/qerv_pkg.sv */
package qerv_pkg;

   // Datapath geometry
   localparam int W       = 4;
   localparam int XLEN    = 32;
   localparam int NIBBLES = XLEN / W;
   localparam int CNT_W   = 3;
   localparam int REG_AW  = 5;

   localparam logic [XLEN-1:0] RESET_PC = '0;

   typedef logic [W-1:0]      nibble_t;
   typedef logic [REG_AW-1:0] reg_addr_t;
   typedef logic [XLEN-1:0]   word_t;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_PASS_B
   } alu_op_e;

   typedef enum logic [2:0] {
      OPC_OP,
      OPC_OP_IMM,
      OPC_LUI,
      OPC_BRANCH,
      OPC_OTHER
   } opcode_e;

   typedef enum logic [1:0] {
      IMM_I,
      IMM_B,
      IMM_U
   } imm_fmt_e;

   typedef enum logic [1:0] {
      ST_FETCH,
      ST_DECODE,
      ST_RFREQ,
      ST_RUN
   } state_e;

endpackage

/* common/qerv_dec_if.sv */
interface qerv_dec_if;

   qerv_pkg::alu_op_e   alu_op;
   logic                op_b_imm;
   logic                rd_we;
   qerv_pkg::reg_addr_t rd_addr;
   qerv_pkg::reg_addr_t rs1_addr;
   qerv_pkg::reg_addr_t rs2_addr;
   logic                is_branch;
   logic                br_ne;
   qerv_pkg::imm_fmt_e  imm_fmt;

   modport decoder (
      output alu_op, op_b_imm, rd_we, rd_addr, rs1_addr, rs2_addr,
      output is_branch, br_ne, imm_fmt
   );

   modport state  (input rd_we);
   modport immdec (input imm_fmt);
   modport alu    (input alu_op, op_b_imm);
   modport ctrl   (input is_branch, br_ne);

endinterface

/* hdl/qerv_state.sv */
module qerv_state (
   input  logic       clk,
   input  logic       i_rst_n,
   input  logic       i_ibus_ack,
   input  logic       i_rf_ready,
   output logic       o_ibus_cyc,
   output logic       o_rf_rreq,
   output logic       o_cnt_en,
   output logic       o_cnt_first,
   output logic       o_cnt_done,
   output logic       o_wen0,
   qerv_dec_if.state  dec
);

   qerv_pkg::state_e           state;
   logic [qerv_pkg::CNT_W-1:0] cnt;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state      <= qerv_pkg::ST_FETCH;
         o_ibus_cyc <= 1'b0;
         o_rf_rreq  <= 1'b0;
         cnt        <= '0;
      end else begin
         case (state)
            qerv_pkg::ST_FETCH: begin
               // Hold cyc until the bus acks
               if (o_ibus_cyc && i_ibus_ack) begin
                  o_ibus_cyc <= 1'b0;
                  state      <= qerv_pkg::ST_DECODE;
               end else begin
                  o_ibus_cyc <= 1'b1;
               end
            end
            qerv_pkg::ST_DECODE: begin
               o_rf_rreq <= 1'b1;
               state     <= qerv_pkg::ST_RFREQ;
            end
            qerv_pkg::ST_RFREQ: begin
               if (i_rf_ready) begin
                  o_rf_rreq <= 1'b0;
                  cnt       <= '0;
                  state     <= qerv_pkg::ST_RUN;
               end
            end
            qerv_pkg::ST_RUN: begin
               cnt <= cnt + 1'b1;
               // Next fetch starts right after the last nibble
               if (o_cnt_done) begin
                  o_ibus_cyc <= 1'b1;
                  state      <= qerv_pkg::ST_FETCH;
               end
            end
            default: begin
               state <= qerv_pkg::ST_FETCH;
            end
         endcase
      end
   end

   assign o_cnt_en    = (state == qerv_pkg::ST_RUN);
   assign o_cnt_first = o_cnt_en && (cnt == '0);
   assign o_cnt_done  = o_cnt_en && (cnt == qerv_pkg::CNT_W'(qerv_pkg::NIBBLES - 1));

   // Write only while nibbles stream
   assign o_wen0 = o_cnt_en && dec.rd_we;

endmodule

/* hdl/qerv_decode.sv */
module qerv_decode (
   input  logic            clk,
   input  logic            i_rst_n,
   input  logic            i_ibus_ack,
   input  qerv_pkg::word_t i_ibus_rdt,
   qerv_dec_if.decoder     dec
);

   qerv_pkg::word_t   ir;
   qerv_pkg::opcode_e opc;
   logic [2:0]        funct3;
   logic              f3_ok;
   logic              alu_class;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         ir <= '0;
      end else if (i_ibus_ack) begin
         ir <= i_ibus_rdt;
      end
   end

   assign funct3 = ir[14:12];

   always_comb begin
      case (ir[6:0])
         7'b0110011: opc = qerv_pkg::OPC_OP;
         7'b0010011: opc = qerv_pkg::OPC_OP_IMM;
         7'b0110111: opc = qerv_pkg::OPC_LUI;
         7'b1100011: opc = qerv_pkg::OPC_BRANCH;
         default:    opc = qerv_pkg::OPC_OTHER;
      endcase
   end

   // Shifts and set-less-than encodings leave f3_ok low
   always_comb begin
      dec.alu_op = qerv_pkg::ALU_ADD;
      f3_ok      = 1'b1;
      case (funct3)
         3'b000: begin
            if (opc == qerv_pkg::OPC_OP && ir[30]) begin
               dec.alu_op = qerv_pkg::ALU_SUB;
            end
         end
         3'b100: dec.alu_op = qerv_pkg::ALU_XOR;
         3'b110: dec.alu_op = qerv_pkg::ALU_OR;
         3'b111: dec.alu_op = qerv_pkg::ALU_AND;
         default: f3_ok = 1'b0;
      endcase
      if (opc == qerv_pkg::OPC_LUI) begin
         dec.alu_op = qerv_pkg::ALU_PASS_B;
      end
   end

   assign alu_class = (opc == qerv_pkg::OPC_OP) || (opc == qerv_pkg::OPC_OP_IMM);

   assign dec.rd_addr  = ir[11:7];
   assign dec.rs1_addr = ir[19:15];
   assign dec.rs2_addr = ir[24:20];

   assign dec.op_b_imm = (opc == qerv_pkg::OPC_OP_IMM) || (opc == qerv_pkg::OPC_LUI);
   assign dec.rd_we    = ((alu_class && f3_ok) || (opc == qerv_pkg::OPC_LUI)) &&
                         (ir[11:7] != '0);

   // BEQ and BNE only
   assign dec.is_branch = (opc == qerv_pkg::OPC_BRANCH) && (funct3[2:1] == 2'b00);
   assign dec.br_ne     = funct3[0];

   assign dec.imm_fmt = (opc == qerv_pkg::OPC_LUI)    ? qerv_pkg::IMM_U :
                        (opc == qerv_pkg::OPC_BRANCH) ? qerv_pkg::IMM_B :
                                                        qerv_pkg::IMM_I;

endmodule

/* hdl/qerv_immdec.sv */
module qerv_immdec (
   input  logic              clk,
   input  logic              i_ibus_ack,
   input  qerv_pkg::word_t   i_ibus_rdt,
   input  logic              i_cnt_en,
   output qerv_pkg::nibble_t o_imm,
   qerv_dec_if.immdec        dec
);

   qerv_pkg::word_t imm_sr;
   qerv_pkg::word_t imm_word;
   logic            ack_q;

   // Rearranged from the raw word once the format is known
   always_comb begin
      case (dec.imm_fmt)
         qerv_pkg::IMM_B: begin
            imm_word = {{19{imm_sr[31]}}, imm_sr[31], imm_sr[7],
                        imm_sr[30:25], imm_sr[11:8], 1'b0};
         end
         qerv_pkg::IMM_U: begin
            imm_word = {imm_sr[31:12], 12'b0};
         end
         default: begin
            imm_word = {{20{imm_sr[31]}}, imm_sr[31:20]};
         end
      endcase
   end

   // Raw word lands at ack, formatted in the decode cycle,
   // then shifted out LSB nibble first
   always_ff @(posedge clk) begin
      ack_q <= i_ibus_ack;
      if (i_ibus_ack) begin
         imm_sr <= i_ibus_rdt;
      end else if (ack_q) begin
         imm_sr <= imm_word;
      end else if (i_cnt_en) begin
         imm_sr <= {{qerv_pkg::W{1'b0}}, imm_sr[qerv_pkg::XLEN-1:qerv_pkg::W]};
      end
   end

   assign o_imm = imm_sr[qerv_pkg::W-1:0];

endmodule

/* hdl/qerv_alu.sv */
module qerv_alu (
   input  logic              clk,
   input  logic              i_cnt_en,
   input  logic              i_cnt_first,
   input  qerv_pkg::nibble_t i_rs1,
   input  qerv_pkg::nibble_t i_rs2,
   input  qerv_pkg::nibble_t i_imm,
   output qerv_pkg::nibble_t o_rd,
   output logic              o_eq,
   qerv_dec_if.alu           dec
);

   qerv_pkg::nibble_t    op_b;
   qerv_pkg::nibble_t    add_b;
   logic [qerv_pkg::W:0] sum;
   logic                 sub;
   logic                 carry_in;
   logic                 carry_q;
   logic                 eq_q;

   assign op_b = dec.op_b_imm ? i_imm : i_rs2;
   assign sub  = (dec.alu_op == qerv_pkg::ALU_SUB);

   // rs1 - b as rs1 + ~b + 1, the +1 entering at nibble 0
   assign add_b    = sub ? ~op_b : op_b;
   assign carry_in = i_cnt_first ? sub : carry_q;
   assign sum      = {1'b0, i_rs1} + {1'b0, add_b} + {{qerv_pkg::W{1'b0}}, carry_in};

   // Includes the current pair so the last nibble counts at the end of the run
   assign o_eq = (i_rs1 == i_rs2) && (i_cnt_first || eq_q);

   always_ff @(posedge clk) begin
      if (i_cnt_en) begin
         carry_q <= sum[qerv_pkg::W];
         eq_q    <= o_eq;
      end
   end

   always_comb begin
      case (dec.alu_op)
         qerv_pkg::ALU_AND:    o_rd = i_rs1 & op_b;
         qerv_pkg::ALU_OR:     o_rd = i_rs1 | op_b;
         qerv_pkg::ALU_XOR:    o_rd = i_rs1 ^ op_b;
         qerv_pkg::ALU_PASS_B: o_rd = op_b;
         default:              o_rd = sum[qerv_pkg::W-1:0];
      endcase
   end

endmodule

/* hdl/qerv_ctrl.sv */
module qerv_ctrl (
   input  logic              clk,
   input  logic              i_rst_n,
   input  logic              i_cnt_en,
   input  logic              i_cnt_first,
   input  logic              i_cnt_done,
   input  qerv_pkg::nibble_t i_imm,
   input  logic              i_eq,
   output qerv_pkg::word_t   o_pc,
   qerv_dec_if.ctrl          dec
);

   qerv_pkg::nibble_t    pc_nib;
   qerv_pkg::nibble_t    inc;
   logic [qerv_pkg::W:0] p4_sum;
   logic [qerv_pkg::W:0] tgt_sum;
   logic                 p4_c;
   logic                 tgt_c;
   qerv_pkg::word_t      p4_sr;
   qerv_pkg::word_t      tgt_sr;
   qerv_pkg::word_t      p4_next;
   qerv_pkg::word_t      tgt_next;
   logic                 take;

   assign pc_nib = o_pc[qerv_pkg::W-1:0];
   assign inc    = i_cnt_first ? qerv_pkg::nibble_t'(4) : '0;

   // Two serial adders, carries cleared at nibble 0
   assign p4_sum  = {1'b0, pc_nib} + {1'b0, inc} +
                    {{qerv_pkg::W{1'b0}}, !i_cnt_first && p4_c};
   assign tgt_sum = {1'b0, pc_nib} + {1'b0, i_imm} +
                    {{qerv_pkg::W{1'b0}}, !i_cnt_first && tgt_c};

   assign p4_next  = {p4_sum[qerv_pkg::W-1:0], p4_sr[qerv_pkg::XLEN-1:qerv_pkg::W]};
   assign tgt_next = {tgt_sum[qerv_pkg::W-1:0], tgt_sr[qerv_pkg::XLEN-1:qerv_pkg::W]};

   assign take = dec.is_branch && (dec.br_ne ? !i_eq : i_eq);

   always_ff @(posedge clk) begin
      if (i_cnt_en) begin
         p4_c   <= p4_sum[qerv_pkg::W];
         tgt_c  <= tgt_sum[qerv_pkg::W];
         p4_sr  <= p4_next;
         tgt_sr <= tgt_next;
      end
   end

   // PC rotates through the run, new value lands on the last nibble
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_pc <= qerv_pkg::RESET_PC;
      end else if (i_cnt_done) begin
         o_pc <= take ? tgt_next : p4_next;
      end else if (i_cnt_en) begin
         o_pc <= {pc_nib, o_pc[qerv_pkg::XLEN-1:qerv_pkg::W]};
      end
   end

endmodule

/* hdl/qerv_top.sv */
module qerv_top (
   input  logic                clk,
   input  logic                i_rst_n,
   // Instruction bus
   output qerv_pkg::word_t     o_ibus_adr,
   output logic                o_ibus_cyc,
   input  qerv_pkg::word_t     i_ibus_rdt,
   input  logic                i_ibus_ack,
   // Register file
   output logic                o_rf_rreq,
   input  logic                i_rf_ready,
   output qerv_pkg::reg_addr_t o_rreg0,
   output qerv_pkg::reg_addr_t o_rreg1,
   input  qerv_pkg::nibble_t   i_rdata0,
   input  qerv_pkg::nibble_t   i_rdata1,
   output qerv_pkg::reg_addr_t o_wreg0,
   output logic                o_wen0,
   output qerv_pkg::nibble_t   o_wdata0
);

   logic              cnt_en;
   logic              cnt_first;
   logic              cnt_done;
   logic              alu_eq;
   qerv_pkg::nibble_t imm;

   qerv_dec_if dec ();

   qerv_state state (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_ibus_ack  (i_ibus_ack),
      .i_rf_ready  (i_rf_ready),
      .o_ibus_cyc  (o_ibus_cyc),
      .o_rf_rreq   (o_rf_rreq),
      .o_cnt_en    (cnt_en),
      .o_cnt_first (cnt_first),
      .o_cnt_done  (cnt_done),
      .o_wen0      (o_wen0),
      .dec         (dec.state)
   );

   qerv_decode decode (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_ack (i_ibus_ack),
      .i_ibus_rdt (i_ibus_rdt),
      .dec        (dec.decoder)
   );

   qerv_immdec immdec (
      .clk        (clk),
      .i_ibus_ack (i_ibus_ack),
      .i_ibus_rdt (i_ibus_rdt),
      .i_cnt_en   (cnt_en),
      .o_imm      (imm),
      .dec        (dec.immdec)
   );

   qerv_alu alu (
      .clk         (clk),
      .i_cnt_en    (cnt_en),
      .i_cnt_first (cnt_first),
      .i_rs1       (i_rdata0),
      .i_rs2       (i_rdata1),
      .i_imm       (imm),
      .o_rd        (o_wdata0),
      .o_eq        (alu_eq),
      .dec         (dec.alu)
   );

   qerv_ctrl ctrl (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_cnt_en    (cnt_en),
      .i_cnt_first (cnt_first),
      .i_cnt_done  (cnt_done),
      .i_imm       (imm),
      .i_eq        (alu_eq),
      .o_pc        (o_ibus_adr),
      .dec         (dec.ctrl)
   );

   // Register indices come straight from the decoded word
   assign o_rreg0 = dec.rs1_addr;
   assign o_rreg1 = dec.rs2_addr;
   assign o_wreg0 = dec.rd_addr;

endmodule

/* bench/qerv_tb_models.sv */
module imem_model (
   input  logic            clk,
   input  logic            i_rst_n,
   input  logic            i_cyc,
   input  qerv_pkg::word_t i_adr,
   output logic            o_ack,
   output qerv_pkg::word_t o_rdt
);

   qerv_pkg::word_t mem [0:63];
   bit              enable = 1'b0;
   logic            ack_q = 1'b0;
   qerv_pkg::word_t rdt_q = '0;
   int              wait_cnt = -1;

   // FENCE encodings, each tagged with its own index
   initial begin
      for (int i = 0; i < 64; i++) begin
         mem[i] = {25'(i), 7'b0001111};
      end
   end

   always @(negedge clk) begin
      ack_q <= 1'b0;
      if (!i_rst_n) begin
         wait_cnt = -1;
      end else if (i_cyc && !ack_q && enable) begin
         if (wait_cnt < 0) begin
            wait_cnt = $urandom % 4;
         end
         if (wait_cnt == 0) begin
            ack_q    <= 1'b1;
            rdt_q    <= mem[i_adr[7:2]];
            wait_cnt = -1;
         end else begin
            wait_cnt--;
         end
      end
   end

   assign o_ack = ack_q;
   assign o_rdt = rdt_q;

endmodule

module regfile_model (
   input  logic                clk,
   input  logic                i_rst_n,
   input  logic                i_rreq,
   output logic                o_ready,
   input  qerv_pkg::reg_addr_t i_rreg0,
   input  qerv_pkg::reg_addr_t i_rreg1,
   output qerv_pkg::nibble_t   o_rdata0,
   output qerv_pkg::nibble_t   o_rdata1,
   input  qerv_pkg::reg_addr_t i_wreg0,
   input  logic                i_wen0,
   input  qerv_pkg::nibble_t   i_wdata0
);

   qerv_pkg::word_t   regs [0:31];
   bit                wen_seen = 1'b0;
   logic              ready_q = 1'b0;
   qerv_pkg::nibble_t rd0_q = '0;
   qerv_pkg::nibble_t rd1_q = '0;
   int                wait_cnt = -1;
   int                nib = -1;
   bit                wrote;
   qerv_pkg::word_t   wword;

   initial begin
      for (int i = 0; i < 32; i++) begin
         regs[i] = '0;
      end
   end

   // nib is the index of the nibble currently on the read lines
   always @(negedge clk) begin
      ready_q <= 1'b0;
      if (i_wen0) begin
         wen_seen = 1'b1;
      end
      if (!i_rst_n) begin
         wait_cnt = -1;
         nib      = -1;
      end else if (nib >= 0) begin
         nib++;
         if (nib == 8) begin
            if (wrote) begin
               regs[i_wreg0] = wword;
            end
            nib = -1;
         end else begin
            rd0_q <= regs[i_rreg0][nib*4 +: 4];
            rd1_q <= regs[i_rreg1][nib*4 +: 4];
         end
      end else if (ready_q) begin
         nib   = 0;
         wrote = 1'b0;
         rd0_q <= regs[i_rreg0][3:0];
         rd1_q <= regs[i_rreg1][3:0];
      end else if (i_rreq) begin
         if (wait_cnt < 0) begin
            wait_cnt = $urandom % 4;
         end
         if (wait_cnt == 0) begin
            ready_q  <= 1'b1;
            wait_cnt = -1;
         end else begin
            wait_cnt--;
         end
      end
   end

   // Result nibble is taken at the edge that consumes the matching read nibble
   always @(posedge clk) begin
      if (nib >= 0) begin
         wrote             = wrote || i_wen0;
         wword[nib*4 +: 4] = i_wdata0;
      end
   end

   assign o_ready  = ready_q;
   assign o_rdata0 = rd0_q;
   assign o_rdata1 = rd1_q;

endmodule

/* bench/tb_qerv.sv */
module tb_qerv;

   logic                clk = 1'b0;
   logic                rst_n;
   qerv_pkg::word_t     ibus_adr;
   qerv_pkg::word_t     ibus_rdt;
   logic                ibus_cyc;
   logic                ibus_ack;
   logic                rf_rreq;
   logic                rf_ready;
   qerv_pkg::reg_addr_t rreg0;
   qerv_pkg::reg_addr_t rreg1;
   qerv_pkg::reg_addr_t wreg0;
   qerv_pkg::nibble_t   rdata0;
   qerv_pkg::nibble_t   rdata1;
   qerv_pkg::nibble_t   wdata0;
   logic                wen0;
   int                  errors = 0;
   qerv_pkg::word_t     cur_pc;

   always #50 clk = ~clk;

   qerv_top dut0 (
      .clk        (clk),
      .i_rst_n    (rst_n),
      .o_ibus_adr (ibus_adr),
      .o_ibus_cyc (ibus_cyc),
      .i_ibus_rdt (ibus_rdt),
      .i_ibus_ack (ibus_ack),
      .o_rf_rreq  (rf_rreq),
      .i_rf_ready (rf_ready),
      .o_rreg0    (rreg0),
      .o_rreg1    (rreg1),
      .i_rdata0   (rdata0),
      .i_rdata1   (rdata1),
      .o_wreg0    (wreg0),
      .o_wen0     (wen0),
      .o_wdata0   (wdata0)
   );

   imem_model imem0 (
      .clk     (clk),
      .i_rst_n (rst_n),
      .i_cyc   (ibus_cyc),
      .i_adr   (ibus_adr),
      .o_ack   (ibus_ack),
      .o_rdt   (ibus_rdt)
   );

   regfile_model rf0 (
      .clk      (clk),
      .i_rst_n  (rst_n),
      .i_rreq   (rf_rreq),
      .o_ready  (rf_ready),
      .i_rreg0  (rreg0),
      .i_rreg1  (rreg1),
      .o_rdata0 (rdata0),
      .o_rdata1 (rdata1),
      .i_wreg0  (wreg0),
      .i_wen0   (wen0),
      .i_wdata0 (wdata0)
   );

   function automatic qerv_pkg::word_t sext12(input logic [11:0] imm);
      return {{20{imm[11]}}, imm};
   endfunction

   task automatic check_word(input string name, input qerv_pkg::word_t exp,
                             input qerv_pkg::word_t got);
      if (got !== exp) begin
         errors++;
         $display("MISMATCH at %0t: %s expected %h got %h", $time, name, exp, got);
      end
   endtask

   task automatic check_no_write(input string what);
      if (rf0.wen_seen) begin
         errors++;
         $display("o_wen0 went high during %s at %0t", what, $time);
      end
   endtask

   // Ends one cycle after the fetch is seen, so register writes have settled
   task automatic wait_fetch(output qerv_pkg::word_t adr);
      int n;
      n = 0;
      @(negedge clk);
      while (!ibus_cyc && n < 200) begin
         @(negedge clk);
         n++;
      end
      if (!ibus_cyc) begin
         errors++;
         $display("Timeout at %0t: no instruction fetch within 200 cycles", $time);
      end
      adr = ibus_adr;
      @(posedge clk);
   endtask

   task automatic exec(input qerv_pkg::word_t instr, input qerv_pkg::word_t exp_next);
      int              n;
      qerv_pkg::word_t next;
      n = 0;
      imem0.mem[cur_pc[7:2]] = instr;
      rf0.wen_seen = 1'b0;
      imem0.enable = 1'b1;
      @(posedge clk);
      while (!ibus_ack && n < 200) begin
         @(posedge clk);
         n++;
      end
      imem0.enable = 1'b0;
      if (!ibus_ack) begin
         errors++;
         $display("Timeout at %0t: fetch of %h was never acknowledged", $time, cur_pc);
      end
      wait_fetch(next);
      check_word("o_ibus_adr", exp_next, next);
      cur_pc = next;
   endtask

   task automatic test_reg_ops();
      qerv_pkg::word_t a;
      qerv_pkg::word_t b;
      qerv_pkg::word_t exp;
      logic [2:0]      f3;
      logic [6:0]      f7;
      for (int op = 0; op < 5; op++) begin
         a = $urandom;
         b = $urandom;
         rf0.regs[1] = a;
         rf0.regs[2] = b;
         rf0.regs[3] = '0;
         f7 = 7'h00;
         case (op)
            0: begin
               f3  = 3'b000;
               exp = a + b;
            end
            1: begin
               f3  = 3'b000;
               f7  = 7'h20;
               exp = a - b;
            end
            2: begin
               f3  = 3'b111;
               exp = a & b;
            end
            3: begin
               f3  = 3'b110;
               exp = a | b;
            end
            default: begin
               f3  = 3'b100;
               exp = a ^ b;
            end
         endcase
         exec({f7, 5'd2, 5'd1, f3, 5'd3, 7'b0110011}, cur_pc + 4);
         check_word("x3", exp, rf0.regs[3]);
      end
   endtask

   task automatic test_imm_ops();
      qerv_pkg::word_t a;
      qerv_pkg::word_t exp;
      logic [11:0]     imm;
      logic [2:0]      f3;
      for (int op = 0; op < 4; op++) begin
         a   = $urandom;
         imm = 12'h800 | 12'($urandom);
         rf0.regs[1] = a;
         rf0.regs[4] = '0;
         case (op)
            0: begin
               f3  = 3'b000;
               exp = a + sext12(imm);
            end
            1: begin
               f3  = 3'b111;
               exp = a & sext12(imm);
            end
            2: begin
               f3  = 3'b110;
               exp = a | sext12(imm);
            end
            default: begin
               f3  = 3'b100;
               exp = a ^ sext12(imm);
            end
         endcase
         exec({imm, 5'd1, f3, 5'd4, 7'b0010011}, cur_pc + 4);
         check_word("x4", exp, rf0.regs[4]);
      end
   endtask

   task automatic test_lui();
      logic [19:0] imm;
      imm = 20'($urandom);
      rf0.regs[5] = '1;
      exec({imm, 5'd5, 7'b0110111}, cur_pc + 4);
      check_word("x5", {imm, 12'h000}, rf0.regs[5]);
   endtask

   // Case bit 1 picks BNE, bit 0 makes the operands equal
   task automatic test_branches();
      qerv_pkg::word_t a;
      logic [12:0]     off;
      logic [2:0]      f3;
      bit              taken;
      for (int i = 0; i < 4; i++) begin
         a   = $urandom;
         f3  = i[1] ? 3'b001 : 3'b000;
         off = i[0] ? 13'd16 : 13'h1ff8;
         rf0.regs[6] = a;
         rf0.regs[7] = i[0] ? a : a ^ (32'h1 << ($urandom % 32));
         taken = (f3 == 3'b000) ? i[0] : !i[0];
         exec({off[12], off[10:5], 5'd7, 5'd6, f3, off[4:1], off[11], 7'b1100011},
              taken ? cur_pc + {{19{off[12]}}, off} : cur_pc + 4);
         check_no_write("a branch");
      end
   endtask

   task automatic test_no_write();
      rf0.regs[1] = $urandom;
      rf0.regs[2] = $urandom;
      exec({7'h00, 5'd2, 5'd1, 3'b000, 5'd0, 7'b0110011}, cur_pc + 4);
      check_no_write("an ADD to x0");
      check_word("x0", 32'h0, rf0.regs[0]);
      rf0.regs[8] = 32'h5a5a_1234;
      exec({17'h0_1234, 3'b000, 5'd8, 7'b0001111}, cur_pc + 4);
      check_no_write("an unsupported opcode");
      check_word("x8", 32'h5a5a_1234, rf0.regs[8]);
   endtask

   initial begin
      void'($urandom(92467));
      rst_n = 1'b0;
      repeat (16) begin
         @(negedge clk);
         if (ibus_cyc || rf_rreq || wen0) begin
            errors++;
            $display("A bus request or write enable was high during reset at %0t", $time);
         end
      end
      rst_n = 1'b1;
      wait_fetch(cur_pc);
      check_word("o_ibus_adr", 32'h0, cur_pc);
      test_reg_ops();
      test_imm_ops();
      test_lui();
      test_branches();
      test_no_write();
      $display("errors: %0d", errors);
      if (errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

/* tb.f */
common/qerv_pkg.sv
common/qerv_dec_if.sv
hdl/qerv_state.sv
hdl/qerv_decode.sv
hdl/qerv_immdec.sv
hdl/qerv_alu.sv
hdl/qerv_ctrl.sv
hdl/qerv_top.sv
bench/qerv_tb_models.sv
bench/tb_qerv.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module tb_qerv -o sim_tb_qerv
./obj_dir/sim_tb_qerv > sim.log
cat sim.log

if grep -q "^NO ERRORS$" sim.log; then
   exit 0
else
   exit 1
fi
